// File: common/harness_pkg.sv
// harness_pkg: Wishbone and SRAM widths, step FSM state type, seven-segment constants

package harness_pkg;

    // core side Wishbone bus
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;
    localparam int WB_CTI_WIDTH  = 3;
    localparam int WB_BTE_WIDTH  = 2;

    // board SRAM, two half-words per bus word
    localparam int SRAM_DATA_WIDTH = 16;

    // seven-segment display
    localparam int DIGIT_COUNT = 8;
    localparam int SEG_WIDTH   = 7;

    localparam logic [SEG_WIDTH-1:0] SEG_BLANK = 7'h7f; // active low, all dark

    // run/halt state of the single-step controller
    typedef enum logic {
        STEP_RUN  = 1'b0,
        STEP_HALT = 1'b1
    } step_state_e;

endpackage

// File: common/wb_if.sv
// wb_if: classic Wishbone bus with master and slave modports
`timescale 1ns/1ps

interface wb_if #(
    parameter int ADDR_WIDTH = 32
) ();

    logic                                   cyc;
    logic                                   stb;
    logic                                   we;
    logic [harness_pkg::WB_CTI_WIDTH-1:0]   cti;   // carried, bursts not used
    logic [harness_pkg::WB_BTE_WIDTH-1:0]   bte;
    logic [harness_pkg::WB_SEL_WIDTH-1:0]   sel;
    logic [ADDR_WIDTH-1:0]                  addr;
    logic [harness_pkg::WB_DATA_WIDTH-1:0]  wdata;
    logic                                   ack;
    logic [harness_pkg::WB_DATA_WIDTH-1:0]  rdata;

    modport master (
        output cyc, stb, we, cti, bte, sel, addr, wdata,
        input  ack, rdata
    );

    modport slave (
        input  cyc, stb, we, cti, bte, sel, addr, wdata,
        output ack, rdata
    );

endinterface

// File: logic/step_control.sv
// push-button synchronizer, press pulse and run/halt FSM for the core enable
`timescale 1ns/1ps

module step_control (
    input  logic clk,
    input  logic n_rst,
    input  logic i_key,        // high while pressed, asynchronous
    input  logic i_retire_en,
    output logic o_core_en,
    output logic o_capture
);

    harness_pkg::step_state_e state;
    harness_pkg::step_state_e state_next;

    logic [1:0] key_sync;
    logic       key_prev;
    logic       key_press;

    // two flop synchronizer plus previous value for edge detect
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            key_sync <= 2'b00;
            key_prev <= 1'b0;
        end else begin
            key_sync <= {key_sync[0], i_key};
            key_prev <= key_sync[1];
        end
    end

    assign key_press = key_sync[1] & ~key_prev; // one cycle per press

    always_comb begin
        state_next = state;
        case (state)
            harness_pkg::STEP_RUN: begin
                if (i_retire_en) begin
                    state_next = harness_pkg::STEP_HALT;
                end
            end
            harness_pkg::STEP_HALT: begin
                if (key_press) begin
                    state_next = harness_pkg::STEP_RUN;
                end
            end
            default: state_next = harness_pkg::STEP_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= harness_pkg::STEP_RUN;
        end else begin
            state <= state_next;
        end
    end

    assign o_core_en = (state == harness_pkg::STEP_RUN);
    assign o_capture = (state == harness_pkg::STEP_RUN) && i_retire_en; // dropped while halted

    // a capture stops the core from the next cycle
    a_capture_halts: assert property (@(posedge clk) disable iff (!n_rst)
        o_capture |=> !o_core_en);

    // the core only resumes after a detected press
    a_resume_on_press: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(o_core_en) |-> $past(key_press));

endmodule

// File: logic/retire_display.sv
// retire_display: retire value latch and hex to active-low seven-segment decode
`timescale 1ns/1ps

module retire_display (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                i_capture,
    input  logic [harness_pkg::DIGIT_COUNT*4-1:0] i_retire_data,
    output logic [harness_pkg::SEG_WIDTH-1:0]   o_hex [harness_pkg::DIGIT_COUNT]
);

    localparam int DATA_WIDTH = harness_pkg::DIGIT_COUNT * 4;

    logic [DATA_WIDTH-1:0] retire_q;
    logic                  shown;      // a value has been captured since reset

    // gfedcba, active low, bit 0 is segment a
    function automatic logic [harness_pkg::SEG_WIDTH-1:0] seg7_decode(input logic [3:0] nibble);
        logic [harness_pkg::SEG_WIDTH-1:0] seg;
        case (nibble)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'ha:    seg = 7'b0001000;
            4'hb:    seg = 7'b0000011;
            4'hc:    seg = 7'b1000110;
            4'hd:    seg = 7'b0100001;
            4'he:    seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            shown <= 1'b0;
        end else if (i_capture) begin
            shown <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_capture) begin
            retire_q <= i_retire_data;
        end
    end

    for (genvar d = 0; d < harness_pkg::DIGIT_COUNT; d++) begin : g_digit
        always_ff @(posedge clk) begin
            if (!n_rst) begin
                o_hex[d] <= harness_pkg::SEG_BLANK;
            end else if (shown) begin
                o_hex[d] <= seg7_decode(retire_q[4*d +: 4]); // nibble d to digit d
            end
        end
    end

endmodule

// File: sram_wb/sram_wb.sv
// Wishbone slave bridging 32-bit accesses to a 16-bit asynchronous SRAM
`timescale 1ns/1ps

module sram_wb #(
    parameter int                       WB_ADDR_WIDTH   = 32,
    parameter int                       SRAM_ADDR_WIDTH = 20,
    parameter logic [WB_ADDR_WIDTH-1:0] SRAM_BASE_ADDR  = '0
)(
    input  logic                                    clk,
    input  logic                                    n_rst,
    wb_if.slave                                     i_wb,
    output logic [SRAM_ADDR_WIDTH-1:0]              o_sram_addr,
    output logic                                    o_sram_ce_n,
    output logic                                    o_sram_oe_n,
    output logic                                    o_sram_we_n,
    output logic                                    o_sram_lb_n,
    output logic                                    o_sram_ub_n,
    inout  wire  [harness_pkg::SRAM_DATA_WIDTH-1:0] io_sram_dq
);

    localparam int SRAM_DW        = harness_pkg::SRAM_DATA_WIDTH;
    localparam int WB_DW          = harness_pkg::WB_DATA_WIDTH;
    localparam int WORD_IDX_WIDTH = SRAM_ADDR_WIDTH - 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOW,
        ST_HIGH,
        ST_ACK
    } bridge_state_e;

    bridge_state_e state;

    logic                                  req_valid;
    logic [WB_ADDR_WIDTH-1:0]              offset;
    logic                                  addr_hit;
    logic                                  req_hit;
    logic                                  req_we;
    logic [harness_pkg::WB_SEL_WIDTH-1:0]  req_sel;
    logic [WB_DW-1:0]                      req_wdata;
    logic [WORD_IDX_WIDTH-1:0]             req_word;
    logic [SRAM_DW-1:0]                    lo_hold;
    logic [WB_DW-1:0]                      rdata_q;
    logic                                  half_active;
    logic                                  high_half;
    logic [SRAM_DW-1:0]                    dq_out;

    assign req_valid = i_wb.cyc & i_wb.stb;
    assign offset    = i_wb.addr - SRAM_BASE_ADDR;
    assign addr_hit  = (i_wb.addr >= SRAM_BASE_ADDR) &&
                       (offset[WB_ADDR_WIDTH-1:SRAM_ADDR_WIDTH+1] == '0); // window is 2^(N+1) bytes

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= ST_LOW;
                    end
                end
                ST_LOW:  state <= ST_HIGH;
                ST_HIGH: state <= ST_ACK;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request held for the whole access
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            req_hit   <= addr_hit;
            req_we    <= i_wb.we;
            req_sel   <= i_wb.sel;
            req_wdata <= i_wb.wdata;
            req_word  <= offset[SRAM_ADDR_WIDTH:2];
        end
    end

    assign high_half   = (state == ST_HIGH);
    assign half_active = ((state == ST_LOW) || high_half) && req_hit;

    assign o_sram_addr = {req_word, high_half}; // low half even, high half odd
    assign o_sram_ce_n = ~half_active;
    assign o_sram_oe_n = ~(half_active && !req_we);
    assign o_sram_we_n = ~(half_active && req_we);

    always_comb begin
        o_sram_lb_n = 1'b1;
        o_sram_ub_n = 1'b1;
        if (half_active) begin
            if (!req_we) begin
                o_sram_lb_n = 1'b0; // reads take both lanes
                o_sram_ub_n = 1'b0;
            end else if (high_half) begin
                o_sram_lb_n = ~req_sel[2];
                o_sram_ub_n = ~req_sel[3];
            end else begin
                o_sram_lb_n = ~req_sel[0];
                o_sram_ub_n = ~req_sel[1];
            end
        end
    end

    assign dq_out     = high_half ? req_wdata[WB_DW-1:SRAM_DW] : req_wdata[SRAM_DW-1:0];
    assign io_sram_dq = !o_sram_we_n ? dq_out : 'z;

    always_ff @(posedge clk) begin
        if (state == ST_LOW) begin
            lo_hold <= io_sram_dq;
        end
        if (high_half) begin
            rdata_q <= (req_hit && !req_we) ? {io_sram_dq, lo_hold} : '0; // misses read zero
        end
    end

    assign i_wb.ack   = (state == ST_ACK);
    assign i_wb.rdata = rdata_q;

    a_ack_single_cycle: assert property (@(posedge clk) disable iff (!n_rst)
        i_wb.ack |=> !i_wb.ack);

    // an access outside the window never selects the chip
    a_miss_no_ce: assert property (@(posedge clk) disable iff (!n_rst)
        (state == ST_IDLE && req_valid && !addr_hit) |=> o_sram_ce_n [*3]);

endmodule

// File: logic/arch_harness_top.sv
// arch_harness_top: board harness top with step control, retire display and SRAM bridge
`timescale 1ns/1ps

module arch_harness_top #(
    parameter int                       WB_ADDR_WIDTH   = 32,
    parameter int                       SRAM_ADDR_WIDTH = 20,
    parameter logic [WB_ADDR_WIDTH-1:0] SRAM_BASE_ADDR  = '0
)(
    input  logic                                    clk,
    input  logic                                    n_rst,
    input  logic                                    i_key,
    input  logic                                    i_retire_en,
    input  logic [harness_pkg::WB_DATA_WIDTH-1:0]   i_retire_data,

    input  logic                                    i_wb_cyc,
    input  logic                                    i_wb_stb,
    input  logic                                    i_wb_we,
    input  logic [harness_pkg::WB_CTI_WIDTH-1:0]    i_wb_cti,
    input  logic [harness_pkg::WB_BTE_WIDTH-1:0]    i_wb_bte,
    input  logic [harness_pkg::WB_SEL_WIDTH-1:0]    i_wb_sel,
    input  logic [WB_ADDR_WIDTH-1:0]                i_wb_addr,
    input  logic [harness_pkg::WB_DATA_WIDTH-1:0]   i_wb_data,
    output logic                                    o_wb_ack,
    output logic [harness_pkg::WB_DATA_WIDTH-1:0]   o_wb_data,

    output logic                                    o_core_en,

    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex0,
    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex1,
    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex2,
    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex3,
    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex4,
    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex5,
    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex6,
    output logic [harness_pkg::SEG_WIDTH-1:0]       o_hex7,

    output logic [SRAM_ADDR_WIDTH-1:0]              o_sram_addr,
    output logic                                    o_sram_ce_n,
    output logic                                    o_sram_oe_n,
    output logic                                    o_sram_we_n,
    output logic                                    o_sram_lb_n,
    output logic                                    o_sram_ub_n,
    inout  wire  [harness_pkg::SRAM_DATA_WIDTH-1:0] io_sram_dq
);

    logic                                 capture;
    logic [harness_pkg::SEG_WIDTH-1:0]    hex [harness_pkg::DIGIT_COUNT];

    wb_if #(.ADDR_WIDTH(WB_ADDR_WIDTH)) wb_bus ();

    // core side master, driven from the top level pins
    assign wb_bus.cyc   = i_wb_cyc;
    assign wb_bus.stb   = i_wb_stb;
    assign wb_bus.we    = i_wb_we;
    assign wb_bus.cti   = i_wb_cti;
    assign wb_bus.bte   = i_wb_bte;
    assign wb_bus.sel   = i_wb_sel;
    assign wb_bus.addr  = i_wb_addr;
    assign wb_bus.wdata = i_wb_data;
    assign o_wb_ack     = wb_bus.ack;
    assign o_wb_data    = wb_bus.rdata;

    assign o_hex0 = hex[0];
    assign o_hex1 = hex[1];
    assign o_hex2 = hex[2];
    assign o_hex3 = hex[3];
    assign o_hex4 = hex[4];
    assign o_hex5 = hex[5];
    assign o_hex6 = hex[6];
    assign o_hex7 = hex[7]; // most significant nibble

    step_control u_step_control (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_key       (i_key),
        .i_retire_en (i_retire_en),
        .o_core_en   (o_core_en),
        .o_capture   (capture)
    );

    retire_display u_retire_display (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_capture     (capture),
        .i_retire_data (i_retire_data),
        .o_hex         (hex)
    );

    sram_wb #(
        .WB_ADDR_WIDTH   (WB_ADDR_WIDTH),
        .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH),
        .SRAM_BASE_ADDR  (SRAM_BASE_ADDR)
    ) u_sram_wb (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_wb        (wb_bus.slave),
        .o_sram_addr (o_sram_addr),
        .o_sram_ce_n (o_sram_ce_n),
        .o_sram_oe_n (o_sram_oe_n),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_lb_n (o_sram_lb_n),
        .o_sram_ub_n (o_sram_ub_n),
        .io_sram_dq  (io_sram_dq)
    );

endmodule

// File: verification/sram_model.sv
// sram_model: behavioral 16-bit asynchronous SRAM with byte lanes
`timescale 1ns/1ps

module sram_model #(
    parameter int ADDR_WIDTH = 10
)(
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic                  i_ce_n,
    input  logic                  i_oe_n,
    input  logic                  i_we_n,
    input  logic                  i_lb_n,
    input  logic                  i_ub_n,
    inout  wire  [15:0]           io_dq
);

    logic [15:0] mem [2**ADDR_WIDTH];

    // read drives the pins only while selected and not writing
    assign io_dq = (!i_ce_n && !i_oe_n && i_we_n) ? mem[i_addr] : 'z;

    // write is level sensitive, evaluated after the pins settle
    always begin
        @(i_addr, i_ce_n, i_we_n, i_lb_n, i_ub_n, io_dq);
        #1;
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) begin
                mem[i_addr][7:0] = io_dq[7:0];
            end
            if (!i_ub_n) begin
                mem[i_addr][15:8] = io_dq[15:8];
            end
        end
    end

endmodule

// File: verification/arch_harness_tb.sv
// table driven testbench for the board harness and its SRAM model
`timescale 1ns/1ps

module arch_harness_tb;

    localparam int          SRAM_AW   = 10;
    localparam logic [31:0] BASE      = 32'h1000_0000;
    localparam int          NROWS     = 13;
    localparam int          K_WRITE   = 0;
    localparam int          K_READ    = 1;
    localparam int          K_RETIRE  = 2;
    localparam int          K_PRESS   = 3;
    localparam logic [6:0]  SEG_TAB [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
        7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    logic        clk;
    logic        n_rst;
    logic        i_key;
    logic        i_retire_en;
    logic [31:0] i_retire_data;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [2:0]  i_wb_cti;
    logic [1:0]  i_wb_bte;
    logic [3:0]  i_wb_sel;
    logic [31:0] i_wb_addr;
    logic [31:0] i_wb_data;
    logic        o_wb_ack;
    logic [31:0] o_wb_data;
    logic        o_core_en;
    logic [6:0]  hex [8];
    logic [SRAM_AW-1:0] sram_addr;
    logic        ce_n, oe_n, we_n, lb_n, ub_n;
    wire  [15:0] sram_dq;

    int          row_kind [NROWS];
    logic [31:0] row_addr [NROWS];
    logic [31:0] row_data [NROWS];
    logic [3:0]  row_sel  [NROWS];
    logic [31:0] row_exp  [NROWS];
    harness_pkg::step_state_e row_state [NROWS];

    integer      seed = 32'h8ba8_f175;
    int          errors = 0;
    logic        miss_watch = 1'b0;

    arch_harness_top #(
        .SRAM_ADDR_WIDTH (SRAM_AW),
        .SRAM_BASE_ADDR  (BASE)
    ) u_dut (
        .clk (clk), .n_rst (n_rst), .i_key (i_key),
        .i_retire_en (i_retire_en), .i_retire_data (i_retire_data),
        .i_wb_cyc (i_wb_cyc), .i_wb_stb (i_wb_stb), .i_wb_we (i_wb_we),
        .i_wb_cti (i_wb_cti), .i_wb_bte (i_wb_bte), .i_wb_sel (i_wb_sel),
        .i_wb_addr (i_wb_addr), .i_wb_data (i_wb_data),
        .o_wb_ack (o_wb_ack), .o_wb_data (o_wb_data), .o_core_en (o_core_en),
        .o_hex0 (hex[0]), .o_hex1 (hex[1]), .o_hex2 (hex[2]), .o_hex3 (hex[3]),
        .o_hex4 (hex[4]), .o_hex5 (hex[5]), .o_hex6 (hex[6]), .o_hex7 (hex[7]),
        .o_sram_addr (sram_addr), .o_sram_ce_n (ce_n), .o_sram_oe_n (oe_n),
        .o_sram_we_n (we_n), .o_sram_lb_n (lb_n), .o_sram_ub_n (ub_n),
        .io_sram_dq (sram_dq)
    );

    sram_model #(.ADDR_WIDTH(SRAM_AW)) u_sram (
        .i_addr (sram_addr), .i_ce_n (ce_n), .i_oe_n (oe_n), .i_we_n (we_n),
        .i_lb_n (lb_n), .i_ub_n (ub_n), .io_dq (sram_dq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(NROWS * 20 * 40 + 2000);
        $display("watchdog expired before the test sequence finished");
        $display("tests failed");
        $finish;
    end

    always @(negedge ce_n) begin
        if (miss_watch) begin
            errors++;
            $display("sram chip enable fell during an out-of-window access at %0t", $time);
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // bytewise merge by select lanes
    function automatic logic [31:0] merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                          input logic [3:0] sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_row(input int i, input int kind, input logic [31:0] addr,
                           input logic [3:0] sel, input harness_pkg::step_state_e st);
        row_kind[i]  = kind;
        row_addr[i]  = addr;
        row_data[i]  = $random(seed);
        row_sel[i]   = sel;
        row_state[i] = st;
    endtask

    task automatic build_table();
        add_row(0,  K_WRITE,  BASE + 32'h40,  4'hf, harness_pkg::STEP_RUN);
        add_row(1,  K_READ,   BASE + 32'h40,  4'hf, harness_pkg::STEP_RUN);
        add_row(2,  K_WRITE,  BASE + 32'h80,  4'hf, harness_pkg::STEP_RUN);
        add_row(3,  K_WRITE,  BASE + 32'h80,  4'h3, harness_pkg::STEP_RUN);
        add_row(4,  K_WRITE,  BASE + 32'h80,  4'h8, harness_pkg::STEP_RUN);
        add_row(5,  K_READ,   BASE + 32'h80,  4'hf, harness_pkg::STEP_RUN);
        add_row(6,  K_WRITE,  BASE + 32'h800, 4'hf, harness_pkg::STEP_RUN);
        add_row(7,  K_READ,   BASE + 32'h800, 4'hf, harness_pkg::STEP_RUN);
        add_row(8,  K_READ,   BASE - 32'h4,   4'hf, harness_pkg::STEP_RUN);
        add_row(9,  K_RETIRE, 32'h0,          4'h0, harness_pkg::STEP_HALT);
        add_row(10, K_RETIRE, 32'h0,          4'h0, harness_pkg::STEP_HALT);
        add_row(11, K_PRESS,  32'h0,          4'h0, harness_pkg::STEP_RUN);
        add_row(12, K_RETIRE, 32'h0,          4'h0, harness_pkg::STEP_HALT);
        row_exp[1]  = row_data[0];
        row_exp[5]  = merge(merge(row_data[2], row_data[3], 4'h3), row_data[4], 4'h8);
        row_exp[7]  = 32'h0;
        row_exp[8]  = 32'h0;
        row_exp[9]  = row_data[9];
        row_exp[10] = row_data[9];   // dropped while halted
        row_exp[12] = row_data[12];
    endtask

    task automatic check_idle_outputs();
        check_value(o_wb_ack, 1'b0, "ack in reset");
        check_value({ce_n, oe_n, we_n, lb_n, ub_n}, 5'b11111, "sram strobes in reset");
        check_value(o_core_en, 1'b1, "core enable in reset");
        for (int d = 0; d < 8; d++) begin
            check_value(hex[d], harness_pkg::SEG_BLANK, "digit blank in reset");
        end
    endtask

    task automatic bus_access(input int i);
        int wait_cnt;
        logic [31:0] idx;
        i_wb_cyc  = 1'b1;
        i_wb_stb  = 1'b1;
        i_wb_we   = (row_kind[i] == K_WRITE);
        i_wb_addr = row_addr[i];
        i_wb_data = row_data[i];
        i_wb_sel  = row_sel[i];
        miss_watch = (row_addr[i] < BASE) || (row_addr[i] >= BASE + 32'h800);
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (!o_wb_ack && wait_cnt < 10);
        if (!o_wb_ack) begin
            errors++;
            $display("no bus acknowledge within 10 cycles on row %0d", i);
        end else if (row_kind[i] == K_READ) begin
            check_value(o_wb_data, row_exp[i], "read data");
            if (!miss_watch) begin
                idx = (row_addr[i] - BASE) >> 2;
                check_value(u_sram.mem[2*idx], row_exp[i][15:0], "sram low half");
                check_value(u_sram.mem[2*idx+1], row_exp[i][31:16], "sram high half");
            end
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        @(negedge clk);
        miss_watch = 1'b0;
    endtask

    task automatic retire_event(input int i);
        i_retire_en   = 1'b1;
        i_retire_data = row_data[i];
        @(negedge clk);
        i_retire_en = 1'b0;
        check_value(o_core_en, row_state[i] == harness_pkg::STEP_RUN, "core enable");
        @(negedge clk);
        for (int d = 0; d < 8; d++) begin
            check_value(hex[d], SEG_TAB[row_exp[i][4*d +: 4]], "digit segments");
        end
    endtask

    task automatic button_press();
        int wait_cnt;
        i_key = 1'b1;
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (!o_core_en && wait_cnt < 4);
        if (!o_core_en) begin
            errors++;
            $display("core did not resume within 4 cycles of the button press");
        end
        i_key = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        n_rst = 1'b0;
        i_key = 1'b0;
        i_retire_en = 1'b0;
        i_retire_data = '0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we = 1'b0;
        i_wb_cti = 3'b000;
        i_wb_bte = 2'b00;
        i_wb_sel = 4'h0;
        i_wb_addr = '0;
        i_wb_data = '0;
        build_table();
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        n_rst = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        for (int i = 0; i < NROWS; i++) begin
            case (row_kind[i])
                K_WRITE, K_READ: bus_access(i);
                K_RETIRE:        retire_event(i);
                default:         button_press();
            endcase
        end
        $display("%0d errors over %0d table rows", errors, NROWS);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: arch_harness_top.f
common/harness_pkg.sv
common/wb_if.sv
logic/step_control.sv
logic/retire_display.sv
sram_wb/sram_wb.sv
logic/arch_harness_top.sv
verification/sram_model.sv
verification/arch_harness_tb.sv
